/* hdl/ddr_cmd_pkg.sv */
package ddr_cmd_pkg;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_LOAD_MODE = 3'b000,
    CMD_REFRESH   = 3'b001,
    CMD_PRECHARGE = 3'b010,
    CMD_ACTIVE    = 3'b011,
    CMD_WRITE     = 3'b100,
    CMD_READ      = 3'b101,
    CMD_NOP       = 3'b111
  } ddr_cmd_t;

  // burst length 2, sequential, cas latency 2
  localparam logic [12:0] MODE_WORD = 13'b0_0000_0010_0001;

  localparam int unsigned CAS_LAT = 2;

  // row to column delay
  localparam int unsigned T_RCD = 2;

  // precharge period, also used as the mode register set time
  localparam int unsigned T_RP = 2;

  // auto refresh period
  localparam int unsigned T_RFC = 8;

  // address bit that turns a precharge into precharge-all
  localparam int unsigned A10_BIT = 10;

endpackage

/* hdl/ddr_user_pkg.sv */
package ddr_user_pkg;

  localparam int unsigned USER_ADDR_W = 26;

  localparam int unsigned BANK_MSB = 25;
  localparam int unsigned BANK_LSB = 24;

  localparam int unsigned ROW_MSB = 23;
  localparam int unsigned ROW_LSB = 11;

  // column field, sent to the sdram shifted left by one
  localparam int unsigned COL_MSB = 10;
  localparam int unsigned COL_LSB = 1;

  // which port owns the command in flight
  typedef enum logic [1:0] {
    OWN_NONE    = 2'd0,
    OWN_RAND    = 2'd1,
    OWN_BULK    = 2'd2,
    OWN_REFRESH = 2'd3
  } owner_t;

endpackage

/* hdl/ddr_req_if.sv */
`timescale 1ns/1ps

// fields hold steady from req until the one-cycle ack
interface ddr_req_if;

  logic [ddr_user_pkg::USER_ADDR_W-1:0] address;
  logic                                 we;
  logic [3:0]                           we_array;
  logic                                 req;
  logic                                 ack;
  logic [31:0]                          datain;

  modport user (
    output address, we, we_array, req, datain,
    input  ack
  );

  modport arb (
    input  address, we, we_array, req, datain,
    output ack
  );

endinterface

/* hdl/ddr_initializer.sv */
`timescale 1ns/1ps

module ddr_initializer #(
  parameter logic [15:0] init_wait_cycles = 16'd200
) (
  input  logic                  clk_n,
  input  logic                  rst_n,
  input  ddr_cmd_pkg::ddr_cmd_t user_cmd,
  input  logic [12:0]           user_addr,
  input  logic [1:0]            user_bank,
  output logic                  cke,
  output ddr_cmd_pkg::ddr_cmd_t command,
  output logic [12:0]           address,
  output logic [1:0]            bank,
  output logic                  init_done
);

  logic [2:0]            step; // 0 is the power-up wait, then one per command sent
  logic [15:0]           cnt;  // cycles left before the next step
  ddr_cmd_pkg::ddr_cmd_t init_cmd;
  logic [12:0]           init_addr;

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      step      <= 3'd0;
      cnt       <= init_wait_cycles - 16'd1;
      cke       <= 1'b0;
      init_cmd  <= ddr_cmd_pkg::CMD_NOP;
      init_addr <= '0;
      init_done <= 1'b0;
    end else begin
      init_cmd <= ddr_cmd_pkg::CMD_NOP;
      if (!init_done) begin
        if (cnt != 16'd0) begin
          cnt <= cnt - 16'd1;
        end else if (step == 3'd4) begin
          init_done <= 1'b1; // mode register settled, hand pins over
        end else begin
          cke  <= 1'b1;
          step <= step + 3'd1;
          case (step)
            3'd0: begin
              init_cmd                       <= ddr_cmd_pkg::CMD_PRECHARGE;
              init_addr                      <= '0;
              init_addr[ddr_cmd_pkg::A10_BIT] <= 1'b1; // all banks
              cnt                            <= 16'(ddr_cmd_pkg::T_RP - 1);
            end
            3'd3: begin
              init_cmd  <= ddr_cmd_pkg::CMD_LOAD_MODE;
              init_addr <= ddr_cmd_pkg::MODE_WORD;
              cnt       <= 16'(ddr_cmd_pkg::T_RP - 1);
            end
            default: begin
              init_cmd  <= ddr_cmd_pkg::CMD_REFRESH;
              init_addr <= '0;
              cnt       <= 16'(ddr_cmd_pkg::T_RFC - 1);
            end
          endcase
        end
      end
    end
  end

  // pin mux, init sequence first and then the arbiter
  assign command = init_done ? user_cmd : init_cmd;
  assign address = init_done ? user_addr : init_addr;
  assign bank    = init_done ? user_bank : 2'b00;

endmodule

/* hdl/ddr_bank_arbiter.sv */
`timescale 1ns/1ps

module ddr_bank_arbiter (
  input  logic                  clk_n,
  input  logic                  rst_n,
  input  logic                  init_done,
  input  logic                  refresh_strobe,
  ddr_req_if.arb                rand_port,
  ddr_req_if.arb                bulk_port,
  input  logic                  bulk_req_algn,
  output logic                  bulk_req_algn_ack,
  output ddr_cmd_pkg::ddr_cmd_t user_cmd,
  output logic [12:0]           user_addr,
  output logic [1:0]            user_bank,
  output logic                  write_start,
  output logic                  read_start,
  output ddr_user_pkg::owner_t  owner,
  output logic [3:0]            we_array,
  input  logic                  xfer_done
);

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_XFER} state_t;
  typedef enum logic [1:0] {P_ACT, P_COL, P_REF, P_END} step_t; // action when wait_cnt hits 0

  state_t      state;
  step_t       next_step;
  logic [3:0]  wait_cnt;
  logic        refresh_pend;
  logic [12:0] open_row [4];
  logic [3:0]  row_valid;
  logic [1:0]  req_bank;
  logic [12:0] req_row;
  logic [9:0]  req_col;
  logic        req_we;

  logic        lock_req, grant_rand, grant_bulk, grant_acc, at_step, act_now, col_now, row_hit;
  logic [ddr_user_pkg::USER_ADDR_W-1:0] sel_addr;
  logic [1:0]  sel_bank, cur_bank;
  logic [12:0] sel_row, cur_row;
  logic [9:0]  sel_col, cur_col;
  logic        sel_we, cur_we;
  logic [3:0]  sel_we_array;

  // bulk keeps the bus while algn stays high once it has it
  assign lock_req   = bulk_req_algn && (bulk_req_algn_ack || bulk_port.req);
  assign grant_bulk = !refresh_pend && bulk_port.req && (lock_req || !rand_port.req);
  assign grant_rand = !refresh_pend && !lock_req && rand_port.req;
  assign grant_acc  = (state == S_IDLE) && (grant_rand || grant_bulk);

  assign sel_addr     = grant_bulk ? bulk_port.address : rand_port.address;
  assign sel_we       = grant_bulk ? bulk_port.we : rand_port.we;
  assign sel_we_array = grant_bulk ? bulk_port.we_array : rand_port.we_array;
  assign sel_bank     = sel_addr[ddr_user_pkg::BANK_MSB:ddr_user_pkg::BANK_LSB];
  assign sel_row      = sel_addr[ddr_user_pkg::ROW_MSB:ddr_user_pkg::ROW_LSB];
  assign sel_col      = sel_addr[ddr_user_pkg::COL_MSB:ddr_user_pkg::COL_LSB];
  assign row_hit      = row_valid[sel_bank] && (open_row[sel_bank] == sel_row);

  assign cur_bank = (state == S_IDLE) ? sel_bank : req_bank;
  assign cur_row  = (state == S_IDLE) ? sel_row : req_row;
  assign cur_col  = (state == S_IDLE) ? sel_col : req_col;
  assign cur_we   = (state == S_IDLE) ? sel_we : req_we;

  assign at_step = (state == S_WAIT) && (wait_cnt == 4'd0);
  assign act_now = (grant_acc && !row_valid[sel_bank]) || (at_step && next_step == P_ACT);
  assign col_now = (grant_acc && row_hit) || (at_step && next_step == P_COL);

  assign rand_port.ack = xfer_done && (owner == ddr_user_pkg::OWN_RAND);
  assign bulk_port.ack = xfer_done && (owner == ddr_user_pkg::OWN_BULK);

  always_ff @(posedge clk_n) begin
    if (grant_acc) begin
      req_bank <= sel_bank;
      req_row  <= sel_row;
      req_col  <= sel_col;
      req_we   <= sel_we;
      we_array <= sel_we_array;
    end
    if (act_now) open_row[cur_bank] <= cur_row;
  end

  always_ff @(posedge clk_n) begin
    if (!rst_n || !init_done) begin
      state             <= S_IDLE;
      next_step         <= P_END;
      wait_cnt          <= 4'd0;
      refresh_pend      <= 1'b0;
      row_valid         <= 4'b0000;
      owner             <= ddr_user_pkg::OWN_NONE;
      bulk_req_algn_ack <= 1'b0;
      user_cmd          <= ddr_cmd_pkg::CMD_NOP;
      user_addr         <= '0;
      user_bank         <= 2'b00;
      write_start       <= 1'b0;
      read_start        <= 1'b0;
    end else begin
      user_cmd    <= ddr_cmd_pkg::CMD_NOP;
      write_start <= 1'b0;
      read_start  <= 1'b0;
      if (act_now) begin
        user_cmd            <= ddr_cmd_pkg::CMD_ACTIVE;
        user_addr           <= cur_row;
        user_bank           <= cur_bank;
        row_valid[cur_bank] <= 1'b1;
        wait_cnt            <= 4'(ddr_cmd_pkg::T_RCD - 1);
        next_step           <= P_COL;
        state               <= S_WAIT;
      end
      if (col_now) begin
        user_cmd    <= cur_we ? ddr_cmd_pkg::CMD_WRITE : ddr_cmd_pkg::CMD_READ;
        user_addr   <= {2'b00, cur_col, 1'b0};
        user_bank   <= cur_bank;
        write_start <= cur_we;
        read_start  <= !cur_we;
        state       <= S_XFER;
      end
      case (state)
        S_IDLE: begin
          if (refresh_pend) begin
            owner                          <= ddr_user_pkg::OWN_REFRESH;
            user_cmd                       <= ddr_cmd_pkg::CMD_PRECHARGE;
            user_addr                      <= '0;
            user_addr[ddr_cmd_pkg::A10_BIT] <= 1'b1;
            row_valid                      <= 4'b0000;
            wait_cnt                       <= 4'(ddr_cmd_pkg::T_RP - 1);
            next_step                      <= P_REF;
            state                          <= S_WAIT;
          end else begin
            bulk_req_algn_ack <= lock_req;
            if (grant_acc) begin
              owner <= grant_bulk ? ddr_user_pkg::OWN_BULK : ddr_user_pkg::OWN_RAND;
              if (row_valid[sel_bank] && !row_hit) begin // row miss
                user_cmd            <= ddr_cmd_pkg::CMD_PRECHARGE;
                user_addr           <= '0;
                user_bank           <= sel_bank;
                row_valid[sel_bank] <= 1'b0;
                wait_cnt            <= 4'(ddr_cmd_pkg::T_RP - 1);
                next_step           <= P_ACT;
                state               <= S_WAIT;
              end
            end
          end
        end
        S_WAIT: begin
          if (wait_cnt != 4'd0) begin
            wait_cnt <= wait_cnt - 4'd1;
          end else if (next_step == P_REF) begin
            user_cmd     <= ddr_cmd_pkg::CMD_REFRESH;
            refresh_pend <= 1'b0;
            wait_cnt     <= 4'(ddr_cmd_pkg::T_RFC - 2); // idle cycle makes up the last one
            next_step    <= P_END;
          end else if (next_step == P_END) begin
            owner <= ddr_user_pkg::OWN_NONE;
            state <= S_IDLE;
          end
        end
        S_XFER: begin
          if (xfer_done) begin
            owner <= ddr_user_pkg::OWN_NONE;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
      if (refresh_strobe) refresh_pend <= 1'b1; // a new strobe wins over the clear
    end
  end

endmodule

/* hdl/ddr_data_path.sv */
`timescale 1ns/1ps

module ddr_data_path (
  input  logic                 clk_n,
  input  logic                 rst_n,
  input  logic                 write_start,
  input  logic                 read_start,
  input  ddr_user_pkg::owner_t owner,
  input  logic [3:0]           we_array,
  input  logic [31:0]          rand_datain,
  input  logic [31:0]          bulk_datain,
  inout  wire  [15:0]          dq,
  inout  wire                  dqs,
  output logic                 dm,
  output logic [31:0]          dataout,
  output logic                 xfer_done
);

  logic [1:0]                    wr_beat; // bit 0 low half on dq, bit 1 high half
  logic [ddr_cmd_pkg::CAS_LAT:0] rd_pipe; // read command delay line
  logic [31:0]                   wr_word;
  logic [15:0]                   dq_out;
  logic [15:0]                   rd_low;

  assign wr_word = (owner == ddr_user_pkg::OWN_BULK) ? bulk_datain : rand_datain;
  assign dq_out  = wr_beat[0] ? wr_word[15:0] : wr_word[31:16];

  assign dq  = (|wr_beat) ? dq_out : {16{1'bz}};
  assign dqs = (|wr_beat) ? wr_beat[0] : 1'bz; // high on first beat, low on second

  // a beat is masked only when both of its bytes are disabled
  always_comb begin
    if (wr_beat[0]) begin
      dm = ~|we_array[1:0];
    end else if (wr_beat[1]) begin
      dm = ~|we_array[3:2];
    end else begin
      dm = 1'b0;
    end
  end

  always_ff @(posedge clk_n) begin
    if (!rst_n) begin
      wr_beat   <= 2'b00;
      rd_pipe   <= '0;
      xfer_done <= 1'b0;
    end else begin
      wr_beat   <= {wr_beat[0], write_start};
      rd_pipe   <= {rd_pipe[ddr_cmd_pkg::CAS_LAT-1:0], read_start};
      xfer_done <= wr_beat[1] | rd_pipe[ddr_cmd_pkg::CAS_LAT];
    end
  end

  // beats land cas_lat and cas_lat+1 cycles after read
  always_ff @(posedge clk_n) begin
    if (rd_pipe[ddr_cmd_pkg::CAS_LAT-1]) begin
      rd_low <= dq;
    end
    if (rd_pipe[ddr_cmd_pkg::CAS_LAT]) begin
      dataout <= {dq, rd_low}; // held until the next read completes
    end
  end

endmodule

/* hdl/ddr_memory_controller.sv */
`timescale 1ns/1ps

module ddr_memory_controller #(
  parameter logic [15:0] init_wait_cycles = 16'd200
) (
  input  logic                                 clk_n,
  input  logic                                 rst_n,
  output logic                                 cke,
  output ddr_cmd_pkg::ddr_cmd_t                command,
  output logic [12:0]                          address,
  output logic [1:0]                           bank,
  inout  wire  [15:0]                          dq,
  inout  wire                                  dqs,
  output logic                                 dm,
  output logic                                 cs,
  input  logic                                 refresh_strobe,
  input  logic [ddr_user_pkg::USER_ADDR_W-1:0] rand_req_address,
  input  logic                                 rand_req_we,
  input  logic [3:0]                           rand_req_we_array,
  input  logic                                 rand_req,
  output logic                                 rand_req_ack,
  input  logic [31:0]                          rand_req_datain,
  input  logic [ddr_user_pkg::USER_ADDR_W-1:0] bulk_req_address,
  input  logic                                 bulk_req_we,
  input  logic [3:0]                           bulk_req_we_array,
  input  logic                                 bulk_req,
  output logic                                 bulk_req_ack,
  input  logic                                 bulk_req_algn,
  output logic                                 bulk_req_algn_ack,
  input  logic [31:0]                          bulk_req_datain,
  output logic [31:0]                          user_req_dataout
);

  ddr_cmd_pkg::ddr_cmd_t user_cmd;
  logic [12:0]           user_addr;
  logic [1:0]            user_bank;
  logic                  init_done, write_start, read_start, xfer_done;
  ddr_user_pkg::owner_t  owner;
  logic [3:0]            we_array;

  ddr_req_if rand_if ();
  ddr_req_if bulk_if ();

  assign cs = 1'b0; // single rank, always selected

  assign rand_if.address  = rand_req_address;
  assign rand_if.we       = rand_req_we;
  assign rand_if.we_array = rand_req_we_array;
  assign rand_if.req      = rand_req;
  assign rand_if.datain   = rand_req_datain;
  assign rand_req_ack     = rand_if.ack;

  assign bulk_if.address  = bulk_req_address;
  assign bulk_if.we       = bulk_req_we;
  assign bulk_if.we_array = bulk_req_we_array;
  assign bulk_if.req      = bulk_req;
  assign bulk_if.datain   = bulk_req_datain;
  assign bulk_req_ack     = bulk_if.ack;

  ddr_initializer #(.init_wait_cycles(init_wait_cycles)) u_init (
    .clk_n(clk_n), .rst_n(rst_n), .user_cmd(user_cmd), .user_addr(user_addr),
    .user_bank(user_bank), .cke(cke), .command(command), .address(address),
    .bank(bank), .init_done(init_done)
  );

  ddr_bank_arbiter u_arb (
    .clk_n(clk_n), .rst_n(rst_n), .init_done(init_done), .refresh_strobe(refresh_strobe),
    .rand_port(rand_if.arb), .bulk_port(bulk_if.arb), .bulk_req_algn(bulk_req_algn),
    .bulk_req_algn_ack(bulk_req_algn_ack), .user_cmd(user_cmd), .user_addr(user_addr),
    .user_bank(user_bank), .write_start(write_start), .read_start(read_start),
    .owner(owner), .we_array(we_array), .xfer_done(xfer_done)
  );

  ddr_data_path u_data (
    .clk_n(clk_n), .rst_n(rst_n), .write_start(write_start), .read_start(read_start),
    .owner(owner), .we_array(we_array), .rand_datain(rand_if.datain),
    .bulk_datain(bulk_if.datain), .dq(dq), .dqs(dqs), .dm(dm),
    .dataout(user_req_dataout), .xfer_done(xfer_done)
  );

endmodule

/* verif/ddr_sdram_model.sv */
`timescale 1ns/1ps

module ddr_sdram_model (
  input  logic                  clk_n,
  input  logic                  cke,
  input  logic                  cs,
  input  ddr_cmd_pkg::ddr_cmd_t command,
  input  logic [12:0]           address,
  input  logic [1:0]            bank,
  inout  wire  [15:0]           dq,
  input  logic                  dm,
  output logic                  row_err
);

  logic [15:0] mem [logic [25:0]]; // key is {bank, row, column}
  logic [12:0] open_row [4];
  logic [3:0]  row_open = 4'b0000;
  logic [25:0] wr_key;
  logic [25:0] rd_key;
  logic [1:0]  wr_sh = 2'b00;  // write beats due at the next edges
  logic [2:0]  rd_sh = 3'b000; // bits 1 and 2 drive the two read beats
  logic [15:0] rd_data;

  initial row_err = 1'b0;

  // unwritten cells read back a pattern built from the whole key
  function automatic logic [15:0] fetch(input logic [25:0] key);
    if (mem.exists(key)) return mem[key];
    return key[15:0] ^ {6'd0, key[25:16]};
  endfunction

  assign dq = (rd_sh[1] || rd_sh[2]) ? rd_data : {16{1'bz}};

  always @(posedge clk_n) begin
    if (wr_sh[0] && !dm) mem[wr_key] = dq; // dm drops the whole beat
    if (wr_sh[1] && !dm) mem[wr_key + 26'd1] = dq;
    wr_sh <= {wr_sh[0], 1'b0};
    rd_sh <= {rd_sh[1:0], 1'b0};
    if (rd_sh[0]) rd_data <= fetch(rd_key);
    if (rd_sh[1]) rd_data <= fetch(rd_key + 26'd1);
    if (cke && !cs) begin
      case (command)
        ddr_cmd_pkg::CMD_ACTIVE: begin
          open_row[bank] <= address;
          row_open[bank] <= 1'b1;
        end
        ddr_cmd_pkg::CMD_PRECHARGE: begin
          if (address[10]) row_open <= 4'b0000;
          else row_open[bank] <= 1'b0;
        end
        ddr_cmd_pkg::CMD_WRITE, ddr_cmd_pkg::CMD_READ: begin
          if (!row_open[bank]) begin
            $error("column access to bank %0d with no open row", bank);
            row_err <= 1'b1;
          end
          if (command == ddr_cmd_pkg::CMD_WRITE) begin
            wr_sh[0] <= 1'b1;
            wr_key   <= {bank, open_row[bank], address[10:0]};
          end else begin
            rd_sh[0] <= 1'b1;
            rd_key   <= {bank, open_row[bank], address[10:0]};
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* verif/ddr_controller_props.sv */
`timescale 1ns/1ps

module ddr_controller_props (
  input logic                  clk_n,
  input logic                  rst_n,
  input logic                  cke,
  input ddr_cmd_pkg::ddr_cmd_t command,
  input logic [12:0]           address,
  input logic [1:0]            bank,
  input logic                  rand_req_ack,
  input logic                  bulk_req_ack
);

  logic [3:0] bank_active = 4'b0000; // activated and not yet precharged
  logic       prop_fail = 1'b0;

  always @(posedge clk_n) begin
    if (!rst_n) begin
      bank_active <= 4'b0000;
    end else if (command == ddr_cmd_pkg::CMD_ACTIVE) begin
      bank_active[bank] <= 1'b1;
    end else if (command == ddr_cmd_pkg::CMD_PRECHARGE) begin
      if (address[10]) bank_active <= 4'b0000;
      else bank_active[bank] <= 1'b0;
    end
  end

  acks_exclusive: assert property (@(posedge clk_n) disable iff (!rst_n)
    !(rand_req_ack && bulk_req_ack))
    else begin
      prop_fail = 1'b1;
      $error("rand and bulk ack high together");
    end

  rand_ack_pulse: assert property (@(posedge clk_n) disable iff (!rst_n)
    rand_req_ack |=> !rand_req_ack)
    else begin
      prop_fail = 1'b1;
      $error("rand ack longer than one cycle");
    end

  bulk_ack_pulse: assert property (@(posedge clk_n) disable iff (!rst_n)
    bulk_req_ack |=> !bulk_req_ack)
    else begin
      prop_fail = 1'b1;
      $error("bulk ack longer than one cycle");
    end

  nop_while_cke_low: assert property (@(posedge clk_n) disable iff (!rst_n)
    !cke |-> command == ddr_cmd_pkg::CMD_NOP)
    else begin
      prop_fail = 1'b1;
      $error("command other than nop while cke low");
    end

  active_needs_precharge: assert property (@(posedge clk_n) disable iff (!rst_n)
    command == ddr_cmd_pkg::CMD_ACTIVE |-> !bank_active[bank])
    else begin
      prop_fail = 1'b1;
      $error("active to bank %0d without precharge", bank);
    end

endmodule

/* verif/tb_ddr_controller.sv */
`timescale 1ns/1ps

module tb_ddr_controller;

  localparam int INIT_WAIT = 40;
  localparam int RESET_CYCLES = 16;
  localparam int INIT_CYCLES = RESET_CYCLES + INIT_WAIT + 2 + 8 + 8 + 2 + 4;
  localparam logic [12:0] MODE_BL2_CL2 = 13'h021; // cas latency 2 in 6:4, burst 2 in 2:0

  logic                  clk_n = 1'b0;
  logic                  rst_n;
  logic                  cke;
  ddr_cmd_pkg::ddr_cmd_t command;
  logic [12:0]           address;
  logic [1:0]            bank;
  wire  [15:0]           dq;
  wire                   dqs;
  logic                  dm;
  logic                  cs;
  logic                  refresh_strobe;
  logic [25:0]           rand_req_address;
  logic                  rand_req_we;
  logic [3:0]            rand_req_we_array;
  logic                  rand_req;
  logic                  rand_req_ack;
  logic [31:0]           rand_req_datain;
  logic [25:0]           bulk_req_address;
  logic                  bulk_req_we;
  logic [3:0]            bulk_req_we_array;
  logic                  bulk_req;
  logic                  bulk_req_ack;
  logic                  bulk_req_algn;
  logic                  bulk_req_algn_ack;
  logic [31:0]           bulk_req_datain;
  logic [31:0]           user_req_dataout;
  logic                  mem_row_err;
  logic [1:0]            wr_seen = 2'b00; // write command seen one and two negedges back

  logic [31:0] g_port[$];
  logic [31:0] g_we[$];
  logic [31:0] g_we_array[$];
  logic [31:0] g_addr[$];
  logic [31:0] g_data[$];
  logic [31:0] g_exp[$];
  int          err_count = 0;
  int          cycles = 0;
  int          limit = INIT_CYCLES;

  ddr_memory_controller #(.init_wait_cycles(16'(INIT_WAIT))) dut (.*);

  ddr_sdram_model u_model (
    .clk_n(clk_n), .cke(cke), .cs(cs), .command(command), .address(address),
    .bank(bank), .dq(dq), .dm(dm), .row_err(mem_row_err)
  );

  bind ddr_memory_controller ddr_controller_props u_props (
    .clk_n(clk_n), .rst_n(rst_n), .cke(cke), .command(command), .address(address),
    .bank(bank), .rand_req_ack(rand_req_ack), .bulk_req_ack(bulk_req_ack)
  );

  always #4 clk_n = ~clk_n;

  always @(posedge clk_n) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout");
    end
  end

  always @(negedge clk_n) begin
    if (rst_n) begin
      assert (!mem_row_err && !dut.u_props.prop_fail) else begin
        err_count++;
        $display("memory model or bound property reported a protocol error");
        $display("TESTBENCH FAILED");
        $fatal(1, "protocol error");
      end
    end
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      err_count++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // dqs is high on the first write beat and low on the second
  always @(negedge clk_n) begin
    wr_seen <= {wr_seen[0], command == ddr_cmd_pkg::CMD_WRITE};
    if (wr_seen[0]) check_eq("dqs first write beat", 1, dqs);
    if (wr_seen[1]) check_eq("dqs second write beat", 0, dqs);
  end

  task automatic read_golden();
    int    fd;
    string line;
    logic [31:0] f [6];
    fd = $fopen("verif/ddr_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/ddr_golden.txt");
      $display("TESTBENCH FAILED");
      $fatal(1, "missing data file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
          g_port.push_back(f[0]);
          g_we.push_back(f[1]);
          g_we_array.push_back(f[2]);
          g_addr.push_back(f[3]);
          g_data.push_back(f[4]);
          g_exp.push_back(f[5]);
        end
      end
    end
    $fclose(fd);
  endtask

  // waits for the next command other than nop on the pins
  task automatic next_command(output ddr_cmd_pkg::ddr_cmd_t cmd, output logic [12:0] addr);
    do @(negedge clk_n); while (command == ddr_cmd_pkg::CMD_NOP);
    cmd = command;
    addr = address;
  endtask

  task automatic check_init();
    int                    nop_cycles;
    ddr_cmd_pkg::ddr_cmd_t cmd;
    logic [12:0]           addr;
    nop_cycles = 0;
    @(negedge clk_n);
    while (command == ddr_cmd_pkg::CMD_NOP) begin
      check_eq("init cke low", 0, cke);
      nop_cycles++;
      @(negedge clk_n);
    end
    check_eq("init wait cycles", INIT_WAIT, nop_cycles);
    check_eq("init precharge", ddr_cmd_pkg::CMD_PRECHARGE, command);
    check_eq("init precharge a10", 1, address[10]);
    next_command(cmd, addr);
    check_eq("init refresh 1", ddr_cmd_pkg::CMD_REFRESH, cmd);
    next_command(cmd, addr);
    check_eq("init refresh 2", ddr_cmd_pkg::CMD_REFRESH, cmd);
    next_command(cmd, addr);
    check_eq("init load mode", ddr_cmd_pkg::CMD_LOAD_MODE, cmd);
    check_eq("init mode word", MODE_BL2_CL2, addr);
  endtask

  task automatic refresh_pulse();
    int unsigned           gap;
    ddr_cmd_pkg::ddr_cmd_t cmd;
    logic [12:0]           addr;
    gap = $urandom % 6 + 1;
    repeat (gap) @(posedge clk_n);
    refresh_strobe <= 1'b1;
    @(posedge clk_n);
    refresh_strobe <= 1'b0;
    next_command(cmd, addr);
    check_eq("refresh precharge", ddr_cmd_pkg::CMD_PRECHARGE, cmd);
    check_eq("refresh precharge a10", 1, addr[10]);
    next_command(cmd, addr);
    check_eq("refresh command", ddr_cmd_pkg::CMD_REFRESH, cmd);
  endtask

  task automatic check_read(input int i);
    if (g_we[i][0] == 1'b0) check_eq($sformatf("line %0d read", i + 1), g_exp[i], user_req_dataout);
  endtask

  // ri and bi index golden lines for the rand and bulk port, -1 leaves a port idle
  task automatic run_requests(input int ri, input int bi, input bit lock);
    bit r_done;
    bit b_done;
    bit r_ack;
    bit b_ack;
    r_done = (ri < 0);
    b_done = (bi < 0);
    @(posedge clk_n);
    if (ri >= 0) begin
      rand_req_address  <= g_addr[ri][25:0];
      rand_req_we       <= g_we[ri][0];
      rand_req_we_array <= g_we_array[ri][3:0];
      rand_req_datain   <= g_data[ri];
      rand_req          <= 1'b1;
    end
    if (bi >= 0) begin
      bulk_req_address  <= g_addr[bi][25:0];
      bulk_req_we       <= g_we[bi][0];
      bulk_req_we_array <= g_we_array[bi][3:0];
      bulk_req_datain   <= g_data[bi];
      bulk_req_algn     <= lock;
      bulk_req          <= 1'b1;
    end
    while (!(r_done && b_done)) begin
      @(negedge clk_n);
      r_ack = rand_req_ack && !r_done;
      b_ack = bulk_req_ack && !b_done;
      if (r_ack) begin
        if (bi >= 0 && lock) begin
          check_eq("lock bulk done before rand ack", 1, b_done);
          check_eq("lock algn_ack low at rand ack", 0, bulk_req_algn_ack);
        end
        check_read(ri);
        r_done = 1'b1;
      end
      if (b_ack) begin
        if (ri >= 0 && !lock) check_eq("arbitration rand before bulk", 1, r_done);
        if (lock) check_eq("lock algn_ack high at bulk ack", 1, bulk_req_algn_ack);
        check_read(bi);
        b_done = 1'b1;
      end
      @(posedge clk_n);
      if (r_ack) rand_req <= 1'b0;
      if (b_ack) begin
        bulk_req      <= 1'b0;
        bulk_req_algn <= 1'b0;
      end
    end
  endtask

  initial begin
    int idx;
    bit ref_done;
    void'($urandom(32'h9bc6));
    rst_n = 1'b0;
    refresh_strobe = 1'b0;
    rand_req_address = '0;
    rand_req_we = 1'b0;
    rand_req_we_array = 4'h0;
    rand_req = 1'b0;
    rand_req_datain = '0;
    bulk_req_address = '0;
    bulk_req_we = 1'b0;
    bulk_req_we_array = 4'h0;
    bulk_req = 1'b0;
    bulk_req_algn = 1'b0;
    bulk_req_datain = '0;
    read_golden();
    limit = INIT_CYCLES + 60 * g_port.size();
    repeat (RESET_CYCLES) @(posedge clk_n);
    rst_n <= 1'b1;
    check_init();
    idx = 0;
    ref_done = 1'b0;
    while (idx < g_port.size()) begin
      if (!ref_done && idx >= g_port.size() / 2) begin
        refresh_pulse();
        ref_done = 1'b1;
      end
      case (g_port[idx])
        0: run_requests(idx, -1, 1'b0);
        1: run_requests(-1, idx, 1'b0);
        2: run_requests(idx, idx + 1, 1'b0); // rand line with the next bulk line
        default: run_requests(idx + 1, idx, 1'b1); // locked bulk line with the next rand line
      endcase
      idx += (g_port[idx] >= 2) ? 2 : 1;
    end
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verif/ddr_golden.txt */
# port we we_array address data expected, all hex
# port 0 rand, 1 bulk, 2 rand raised with next bulk, 3 locked bulk raised with next rand
0 1 f 0002810 11112222 00000000
1 1 f 0002818 33334444 00000000
0 1 f 0004810 55556666 00000000
1 0 0 0002810 00000000 11112222
0 0 0 0004810 00000000 55556666
0 1 f 1001808 aaaabbbb 00000000
1 1 3 1001808 12345678 00000000
0 0 0 1001808 00000000 aaaa5678
1 0 0 0002818 00000000 33334444
2 1 f 2003804 77778888 00000000
1 1 f 0002810 9999aaaa 00000000
3 0 0 2003804 00000000 77778888
0 0 0 0002810 00000000 9999aaaa
0 0 0 0004810 00000000 55556666

/* tb.f */
hdl/ddr_cmd_pkg.sv
hdl/ddr_user_pkg.sv
hdl/ddr_req_if.sv
hdl/ddr_initializer.sv
hdl/ddr_bank_arbiter.sv
hdl/ddr_data_path.sv
hdl/ddr_memory_controller.sv
verif/ddr_sdram_model.sv
verif/ddr_controller_props.sv
verif/tb_ddr_controller.sv
